/* design/mem_stage_macros.svh */
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// memory stage bus geometry
//////////////////////////////////////////////////////////////////////

// 32-bit words with four byte lanes, as the instruction set defines them.
// the bus address is a byte address and the stage clears its two low bits
// before driving it to the memory

// byte address width
`define MEM_ADDR_W 32

// data word width
`define MEM_DATA_W 32

// byte lanes per data word, one write enable each
`define MEM_LANES 4

`endif

/* design/mem_stage_pkg.sv */
`default_nettype none

`include "mem_stage_macros.svh"

package mem_stage_pkg;

	//////////////////////////////////////////////////////////////////////
	// plain vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [`MEM_ADDR_W-1:0]         addr_t;    // byte address
	typedef logic [`MEM_DATA_W-1:0]         word_t;    // one data word
	typedef logic [`MEM_LANES-1:0]          byte_en_t; // per-lane write enable
	typedef logic [$clog2(`MEM_LANES)-1:0]  lane_t;    // byte lane within a word

	//////////////////////////////////////////////////////////////////////
	// operation and size codes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [0:0] {
		LOAD  = 1'b0,
		STORE = 1'b1
	} mem_op_e;

	// same codes as the pipeline's mem_ctrl field, 2'b00 means no access
	typedef enum logic [1:0] {
		SZ_BYTE = 2'b01,
		SZ_HALF = 2'b10,
		SZ_WORD = 2'b11
	} mem_size_e;

	//////////////////////////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////////////////////////

	// one request as it arrives, 68 bits
	typedef struct packed {
		mem_op_e   op;
		mem_size_e size;
		logic      sign_ext; // loads only
		addr_t     addr;     // byte address, not aligned
		word_t     wdata;    // store data in the low bits
	} mem_req_t;

	// request held in the slot with its alignment status, 69 bits
	typedef struct packed {
		mem_req_t req;
		logic     misaligned;
	} mem_access_t;

	// word-aligned memory bus, 69 bits
	typedef struct packed {
		addr_t    addr;
		word_t    wdata; // already shifted to the enabled lanes
		byte_en_t we;
		logic     rd;
	} mem_bus_t;

	// response returned per request, 34 bits
	typedef struct packed {
		word_t rdata;
		logic  misaligned;
		logic  is_store;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* design/mem_req_slot.sv */
`default_nettype none

// single-entry request holding register
// the alignment check is done here once, as the request is captured,
// so both datapath halves see the same flag
module mem_req_slot import mem_stage_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        req_valid,
	output logic        req_ready,
	input  mem_req_t    req,
	input  logic        accept,    // response register has room
	output logic        issue,
	output mem_access_t access
);

	logic        held;       // slot occupied
	logic        misaligned; // check on the incoming request
	logic        take;
	mem_access_t slot_q;

	//////////////////////////////////////////////////////////////////////
	// alignment
	//////////////////////////////////////////////////////////////////////

	// half needs bit 0 clear, word needs both low bits clear
	always_comb begin
		case (req.size)
			SZ_HALF: misaligned = req.addr[0];
			SZ_WORD: misaligned = |req.addr[1:0];
			default: misaligned = 1'b0; // bytes are always aligned
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// handshake
	//////////////////////////////////////////////////////////////////////

	assign issue     = held & accept;
	assign req_ready = ~held | issue; // refill in the same cycle it drains
	assign take      = req_valid & req_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held <= 1'b0;
		end else if (take) begin
			held <= 1'b1;
		end else if (issue) begin
			held <= 1'b0;
		end
	end

	// payload, only written on a transfer
	always_ff @(posedge clk) begin
		if (take) begin
			slot_q.req        <= req;
			slot_q.misaligned <= misaligned;
		end
	end

	assign access = slot_q;

endmodule

`default_nettype wire

/* design/store_formatter.sv */
`default_nettype none

// drives the word-aligned memory bus for the access in the slot
// store data goes to the same lanes that the byte enables select
module store_formatter import mem_stage_pkg::*; (
	input  logic        issue,
	input  mem_access_t access,
	output mem_bus_t    bus
);

	lane_t    lane;      // low address bits
	logic     enable;    // bus may act this cycle
	byte_en_t lane_mask; // enables before the op check

	assign lane   = access.req.addr[1:0];
	assign enable = issue & ~access.misaligned;

	// one, two or four lanes starting at the addressed one
	always_comb begin
		case (access.req.size)
			SZ_BYTE: lane_mask = byte_en_t'(4'b0001) << lane;
			SZ_HALF: lane_mask = byte_en_t'(4'b0011) << lane;
			SZ_WORD: lane_mask = 4'b1111;
			default: lane_mask = '0;
		endcase
	end

	always_comb begin
		bus.addr  = {access.req.addr[31:2], 2'b00};
		bus.wdata = access.req.wdata << {lane, 3'b000}; // eight bits per lane
		bus.we    = '0;
		bus.rd    = 1'b0;

		// idle unless the slot issues an aligned access
		if (enable) begin
			if (access.req.op == STORE) begin
				bus.we = lane_mask;
			end else begin
				bus.rd = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/load_extractor.sv */
`default_nettype none

// picks the addressed byte or half out of the read word
// and extends it to a full word
module load_extractor import mem_stage_pkg::*; (
	input  mem_access_t access,
	input  word_t       rdata,     // combinational memory read data
	output word_t       load_word
);

	lane_t       lane;
	logic [7:0]  sel_byte;
	logic [15:0] sel_half;
	logic        fill_byte; // extension bit for byte loads
	logic        fill_half; // extension bit for half loads

	assign lane = access.req.addr[1:0];

	//////////////////////////////////////////////////////////////////////
	// lane select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sel_byte = rdata[{lane, 3'b000} +: 8];
		// aligned halves sit at lane 0 or lane 2
		sel_half = lane[1] ? rdata[31:16] : rdata[15:0];
	end

	//////////////////////////////////////////////////////////////////////
	// extension
	//////////////////////////////////////////////////////////////////////

	assign fill_byte = access.req.sign_ext & sel_byte[7];
	assign fill_half = access.req.sign_ext & sel_half[15];

	always_comb begin
		case (access.req.size)
			SZ_BYTE: load_word = {{24{fill_byte}}, sel_byte};
			SZ_HALF: load_word = {{16{fill_half}}, sel_half};
			SZ_WORD: load_word = rdata;
			default: load_word = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/mem_rsp_merge.sv */
`default_nettype none

// response register
// captures the load result and the access status at the end of the
// issue cycle and holds them until the consumer takes them
module mem_rsp_merge import mem_stage_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        issue,
	input  mem_access_t access,
	input  word_t       load_word,
	output logic        accept,    // to the slot
	output logic        rsp_valid,
	input  logic        rsp_ready,
	output mem_rsp_t    rsp
);

	logic  is_store;
	word_t rsp_data;

	assign is_store = (access.req.op == STORE);

	// stores and rejected accesses return zero
	assign rsp_data = (is_store || access.misaligned) ? '0 : load_word;

	// room when empty or when the held response leaves this cycle
	assign accept = ~rsp_valid | rsp_ready;

	//////////////////////////////////////////////////////////////////////
	// valid and payload
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
		end else if (accept) begin
			rsp_valid <= issue; // drops to idle if nothing issued
		end
	end

	// issue is only high while accept is high
	always_ff @(posedge clk) begin
		if (issue) begin
			rsp.rdata      <= rsp_data;
			rsp.misaligned <= access.misaligned;
			rsp.is_store   <= is_store;
		end
	end

endmodule

`default_nettype wire

/* design/mem_stage_top.sv */
`default_nettype none

// standalone memory-access stage
// request slot, then store formatting and load extraction side by side,
// then the response register
module mem_stage_top import mem_stage_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,

	// request side
	input  logic     req_valid,
	output logic     req_ready,
	input  mem_req_t req,

	// memory bus
	output mem_bus_t bus,
	input  word_t    mem_rdata,

	// response side
	output logic     rsp_valid,
	input  logic     rsp_ready,
	output mem_rsp_t rsp
);

	mem_access_t access;    // held request
	logic        issue;
	logic        accept;
	word_t       load_word; // extended read data

	//////////////////////////////////////////////////////////////////////
	// request slot
	//////////////////////////////////////////////////////////////////////

	mem_req_slot u_slot (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.accept    (accept),
		.issue     (issue),
		.access    (access)
	);

	//////////////////////////////////////////////////////////////////////
	// datapath, both zero-cycle
	//////////////////////////////////////////////////////////////////////

	store_formatter u_store (
		.issue  (issue),
		.access (access),
		.bus    (bus)
	);

	load_extractor u_load (
		.access    (access),
		.rdata     (mem_rdata),
		.load_word (load_word)
	);

	//////////////////////////////////////////////////////////////////////
	// response register
	//////////////////////////////////////////////////////////////////////

	mem_rsp_merge u_rsp (
		.clk       (clk),
		.arst_n    (arst_n),
		.issue     (issue),
		.access    (access),
		.load_word (load_word),
		.accept    (accept),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

/* dv/mem_stage_properties.sv */
`default_nettype none

// bus and response protocol checks on the memory stage
module mem_stage_properties import mem_stage_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input logic        issue,
	input mem_access_t access,
	input mem_bus_t    bus,
	input logic        rsp_valid,
	input logic        rsp_ready,
	input mem_rsp_t    rsp
);

	// no write for a rejected access or a load
	no_bad_write: assert property (@(posedge clk) disable iff (!arst_n)
		issue && (access.misaligned || access.req.op == LOAD) |-> bus.we == '0)
		else $error("bus.we active for a misaligned access or a load");

	// stalled response holds still
	rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("rsp changed while rsp_ready was low");

	bus_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!issue |-> !bus.rd && bus.we == '0) // only the issue cycle touches memory
		else $error("bus active in a cycle without issue");

endmodule

bind mem_stage_top mem_stage_properties u_props (
	.clk       (clk),
	.arst_n    (arst_n),
	.issue     (issue),
	.access    (access),
	.bus       (bus),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp       (rsp)
);

`default_nettype wire

/* dv/mem_stage_tb.sv */
`default_nettype none

`include "mem_stage_macros.svh"

module mem_stage_tb import mem_stage_pkg::*; ();

	localparam int FIELDS    = 7;  // columns per case line
	localparam int MAX_CASES = 64;
	localparam int MEM_WORDS = 256 / `MEM_LANES;

	logic     clk = 1'b0;
	logic     arst_n;
	logic     req_valid;
	logic     req_ready;
	mem_req_t req;
	mem_bus_t bus;
	word_t    mem_rdata;
	logic     rsp_valid;
	logic     rsp_ready;
	mem_rsp_t rsp;

	logic [31:0] case_data [0:FIELDS*MAX_CASES-1];
	word_t       mem [0:MEM_WORDS-1];
	int          pending_q[$];      // case indices in flight
	int          num_cases;
	int          next_req;
	int          done_count;
	int          pass_count;
	int          fail_count;
	int          error_count;       // failures outside a case
	int          timeout_limit;
	int          cycle_count = 0;

	always #2 clk = ~clk;

	mem_stage_top uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.bus       (bus),
		.mem_rdata (mem_rdata),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	//////////////////////////////////////////////////////////////////////
	// memory model, 256 bytes
	//////////////////////////////////////////////////////////////////////

	// combinational read, data only while rd is high
	assign mem_rdata = bus.rd ? mem[bus.addr[7:2]] : 'x;

	always @(posedge clk) begin
		for (int l = 0; l < `MEM_LANES; l++) begin
			if (bus.we[l]) begin
				mem[bus.addr[7:2]][8*l +: 8] <= bus.wdata[8*l +: 8];
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("timeout after %0d cycles, %0d of %0d responses received",
				cycle_count, done_count, num_cases);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic mem_req_t case_request(int idx);
		mem_req_t r;
		r.op       = mem_op_e'(case_data[idx*FIELDS][0]);
		r.size     = mem_size_e'(case_data[idx*FIELDS+1][1:0]);
		r.sign_ext = case_data[idx*FIELDS+2][0];
		r.addr     = case_data[idx*FIELDS+3];
		r.wdata    = case_data[idx*FIELDS+4];
		return r;
	endfunction

	// compare the response about to transfer with the oldest case
	task automatic check_response();
		int    idx;
		word_t exp_data;
		logic  exp_mis;
		logic  exp_store;
		bit    ok;
		if (pending_q.size() == 0) begin
			$display("response arrived with no request outstanding");
			error_count++;
			return;
		end
		idx       = pending_q.pop_front();
		exp_data  = case_data[idx*FIELDS+5];
		exp_mis   = case_data[idx*FIELDS+6][0];
		exp_store = case_data[idx*FIELDS][0]; // store when op is 1
		ok        = 1'b1;
		if (rsp.rdata !== exp_data) begin
			$display("ERROR case %0d rsp.rdata expected %h got %h", idx, exp_data, rsp.rdata);
			ok = 1'b0;
		end
		if (rsp.misaligned !== exp_mis) begin
			$display("ERROR case %0d rsp.misaligned expected %h got %h",
				idx, exp_mis, rsp.misaligned);
			ok = 1'b0;
		end
		if (rsp.is_store !== exp_store) begin
			$display("ERROR case %0d rsp.is_store expected %h got %h",
				idx, exp_store, rsp.is_store);
			ok = 1'b0;
		end
		if (ok) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("case %0d addr %h: %s", idx, case_data[idx*FIELDS+3], ok ? "pass" : "FAIL");
		done_count++;
	endtask

	// an active bus belongs to the newest accepted case, still in the slot
	task automatic check_bus(int idx);
		addr_t   exp_addr;
		mem_op_e exp_op;
		if (idx < 0) begin
			$display("memory bus active before any request was accepted");
			error_count++;
			return;
		end
		exp_addr = {case_data[idx*FIELDS+3][31:2], 2'b00};
		exp_op   = mem_op_e'(case_data[idx*FIELDS][0]);
		if (bus.addr !== exp_addr) begin
			$display("ERROR case %0d bus.addr expected %h got %h", idx, exp_addr, bus.addr);
			error_count++;
		end
		if (bus.rd !== (exp_op == LOAD)) begin
			$display("ERROR case %0d bus.rd expected %h got %h", idx, exp_op == LOAD, bus.rd);
			error_count++;
		end
	endtask

	initial begin
		void'($urandom(38));
		arst_n      = 1'b0;
		req_valid   = 1'b0;
		req         = '0;
		rsp_ready   = 1'b0;
		next_req    = 0;
		done_count  = 0;
		pass_count  = 0;
		fail_count  = 0;
		error_count = 0;
		for (int w = 0; w < MEM_WORDS; w++) begin
			for (int l = 0; l < `MEM_LANES; l++) begin
				mem[w][8*l +: 8] = 8'(4*w + l); // each byte holds its own address
			end
		end
		$readmemh("dv/mem_stage_cases.txt", case_data);
		num_cases = 0;
		while (num_cases < MAX_CASES && !$isunknown(case_data[num_cases*FIELDS])) begin
			num_cases++;
		end
		timeout_limit = 40 * num_cases + 100;
		if (num_cases == 0) begin
			$display("no cases could be read from the case file");
			error_count++;
		end

		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		#1;
		if (rsp_valid !== 1'b0) begin
			$display("ERROR rsp_valid after reset expected %h got %h", 1'b0, rsp_valid);
			error_count++;
		end
		if (bus.rd !== 1'b0 || bus.we !== '0) begin
			$display("ERROR bus.rd/bus.we after reset expected 0/0 got %h/%h", bus.rd, bus.we);
			error_count++;
		end
		if (req_ready !== 1'b1) begin
			$display("ERROR req_ready after reset expected %h got %h", 1'b1, req_ready);
			error_count++;
		end

		//////////////////////////////////////////////////////////////////////
		// stream the cases under random back-pressure
		//////////////////////////////////////////////////////////////////////

		while (done_count < num_cases) begin
			@(negedge clk);
			rsp_ready = ($urandom % 3) != 0; // low about a third of the time
			if (next_req < num_cases) begin
				req_valid = 1'b1;
				req       = case_request(next_req);
			end else begin
				req_valid = 1'b0;
			end
			#1; // handshakes settled, transfer at the next rising edge
			if (bus.rd || bus.we != '0) begin
				check_bus(next_req - 1);
			end
			if (req_valid && req_ready) begin
				pending_q.push_back(next_req);
				next_req++;
			end
			if (rsp_valid && rsp_ready) begin
				check_response();
			end
		end

		// nothing may follow the last response
		repeat (10) begin
			@(negedge clk);
			rsp_ready = 1'b1;
			#1;
			if (rsp_valid) begin
				$display("extra response seen after the last case completed");
				error_count++;
			end
		end

		$display("cases passed: %0d, failed: %0d, other errors: %0d",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0 && pass_count == num_cases) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/mem_stage_cases.txt */
// op(0 load, 1 store) size(1 byte, 2 half, 3 word) sign_ext addr wdata
// then expected rdata and expected misaligned
1 3 0 00000010 11223344 00000000 0
0 3 0 00000010 00000000 11223344 0
1 1 0 00000011 000000ab 00000000 0
1 2 0 00000012 0000beef 00000000 0
0 3 0 00000010 00000000 beefab44 0
0 1 1 00000011 00000000 ffffffab 0
0 1 0 00000011 00000000 000000ab 0
0 2 1 00000012 00000000 ffffbeef 0
0 2 0 00000012 00000000 0000beef 0
0 1 1 00000010 00000000 00000044 0
0 2 1 00000010 00000000 ffffab44 0
0 1 1 00000013 00000000 ffffffbe 0
1 3 0 00000020 cafef00d 00000000 0
1 2 0 00000021 00001234 00000000 1
1 3 0 00000022 deadbeef 00000000 1
0 3 0 00000023 00000000 00000000 1
0 2 1 00000023 00000000 00000000 1
0 3 0 00000020 00000000 cafef00d 0
0 3 0 00000040 00000000 43424140 0
0 1 1 00000021 00000000 fffffff0 0
1 1 0 00000023 12345680 00000000 0
0 3 0 00000020 00000000 80fef00d 0

/* mem_stage_top.f */
+incdir+design
design/mem_stage_pkg.sv
design/mem_req_slot.sv
design/store_formatter.sv
design/load_extractor.sv
design/mem_rsp_merge.sv
design/mem_stage_top.sv
dv/mem_stage_properties.sv
dv/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - design
    files:
      - design/mem_stage_pkg.sv
      - design/mem_req_slot.sv
      - design/store_formatter.sv
      - design/load_extractor.sv
      - design/mem_rsp_merge.sv
      - design/mem_stage_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/mem_stage_properties.sv
      - dv/mem_stage_tb.sv
